// ==== verilog/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int excp_w     = 16;
    localparam int excp_idx_w = $clog2(excp_w);
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    // stable counter is two words wide
    localparam int timer_w    = 64;
    // rdtimeh vs rdtimel select bit in the instruction word
    localparam int timer_hi_bit = 10;

    // estat.ecode values
    localparam logic [ecode_w-1:0] ecode_int  = 6'h00;
    localparam logic [ecode_w-1:0] ecode_pil  = 6'h01;
    localparam logic [ecode_w-1:0] ecode_pis  = 6'h02;
    localparam logic [ecode_w-1:0] ecode_pif  = 6'h03;
    localparam logic [ecode_w-1:0] ecode_pme  = 6'h04;
    localparam logic [ecode_w-1:0] ecode_ppi  = 6'h07;
    // adef and adem share one ecode, told apart by esubcode
    localparam logic [ecode_w-1:0] ecode_ade  = 6'h08;
    localparam logic [ecode_w-1:0] ecode_ale  = 6'h09;
    localparam logic [ecode_w-1:0] ecode_sys  = 6'h0B;
    localparam logic [ecode_w-1:0] ecode_brk  = 6'h0C;
    localparam logic [ecode_w-1:0] ecode_ine  = 6'h0D;
    localparam logic [ecode_w-1:0] ecode_ipe  = 6'h0E;
    localparam logic [ecode_w-1:0] ecode_tlbr = 6'h3F;

    localparam logic [esubcode_w-1:0] esubcode_adef = 9'd0;
    localparam logic [esubcode_w-1:0] esubcode_adem = 9'd1;

    // cause bits, first member is bit 15
    // intr is bit 0, named so since int is a keyword
    typedef struct packed {
        logic pil;
        logic pis;
        logic ppi_d;
        logic pme;
        logic tlbr_d;
        logic adem;
        logic ale;
        logic ipe;
        logic ine;
        logic brk;
        logic sys;
        logic ppi_i;
        logic pif;
        logic tlbr_i;
        logic adef;
        logic intr;
    } excp_fields_t;

    // flat view for the priority scan, field view for building the word
    typedef union packed {
        logic [excp_w-1:0] bits;
        excp_fields_t      fields;
    } excp_vec_u;

    typedef enum logic [1:0] {
        idle,
        wait_icache,
        drain
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/wb_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_stage_if;
    import wb_pkg::*;

    // one memory-stage instruction as seen by writeback
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       result;
    logic [xlen-1:0]       mem_addr;
    logic [reg_addr_w-1:0] wreg_index;
    logic                  wreg_en;
    logic                  inst_valid;
    logic                  timer_inst;
    excp_vec_u             excp;
    logic                  ertn;

    modport src (
        output valid, pc, inst, result, mem_addr, wreg_index, wreg_en,
               inst_valid, timer_inst, excp, ertn
    );

    modport commit (
        input valid, pc, inst, result, mem_addr, wreg_index, wreg_en,
              inst_valid, timer_inst, ertn
    );

    // cause encoder needs only the addresses and the vector
    modport cause (input valid, pc, mem_addr, excp);

    modport ctrl (input valid, excp, ertn);

endinterface

`default_nettype wire

// ==== verilog/excp_priority.sv ====
`timescale 1ns/1ps
`default_nettype none

module excp_priority (
    wb_stage_if.cause                      stage,
    output logic [wb_pkg::ecode_w-1:0]     ecode,
    output logic [wb_pkg::esubcode_w-1:0]  esubcode,
    output logic [wb_pkg::xlen-1:0]        badv,
    output logic                           badv_valid,
    output logic                           excp_tlb,
    output logic                           excp_tlbrefill
);
    import wb_pkg::*;

    logic                  hit;
    logic [excp_idx_w-1:0] idx;
    logic                  pc_group;
    logic                  addr_group;
    logic                  tlb_group;

    // lowest set index wins
    always_comb begin
        hit = 1'b0;
        idx = '0;
        for (int i = 0; i < excp_w; i++) begin
            if (!hit && stage.excp.bits[i]) begin
                hit = 1'b1;
                idx = excp_idx_w'(i);
            end
        end
    end

    // index to ecode, no hit falls on index 0 which is ecode 0 anyway
    always_comb begin
        case (idx)
            4'd1:    ecode = ecode_ade;
            4'd2:    ecode = ecode_tlbr;
            4'd3:    ecode = ecode_pif;
            4'd4:    ecode = ecode_ppi;
            4'd5:    ecode = ecode_sys;
            4'd6:    ecode = ecode_brk;
            4'd7:    ecode = ecode_ine;
            4'd8:    ecode = ecode_ipe;
            4'd9:    ecode = ecode_ale;
            4'd10:   ecode = ecode_ade;
            4'd11:   ecode = ecode_tlbr;
            4'd12:   ecode = ecode_pme;
            4'd13:   ecode = ecode_ppi;
            4'd14:   ecode = ecode_pis;
            4'd15:   ecode = ecode_pil;
            default: ecode = ecode_int;
        endcase
    end

    // adem is the only cause with a nonzero subcode
    assign esubcode = (hit && idx == 4'd10) ? esubcode_adem : esubcode_adef;

    // fetch side faults report pc
    assign pc_group   = hit && (idx >= 4'd1) && (idx <= 4'd4);
    // ale, adem and data tlb faults report the access address
    assign addr_group = hit && (idx >= 4'd9);
    // inst tlb 2..4, data tlb 11..15
    assign tlb_group  = hit && (((idx >= 4'd2) && (idx <= 4'd4)) || (idx >= 4'd11));

    assign badv = pc_group ? stage.pc : (addr_group ? stage.mem_addr : '0);

    assign badv_valid     = stage.valid & (pc_group | addr_group);
    assign excp_tlb       = stage.valid & tlb_group;
    // refill only for the two tlbr causes
    assign excp_tlbrefill = stage.valid & hit & ((idx == 4'd2) | (idx == 4'd11));

endmodule

`default_nettype wire

// ==== verilog/flush_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module flush_ctrl_fsm (
    input  logic     clk,
    input  logic     arst_n,
    wb_stage_if.ctrl stage,
    input  logic     icache_busy,
    input  logic     right_ready,
    output logic     left_ready,
    output logic     stall,
    output logic     squash,
    output logic     flush_now,
    output logic     ertn_now
);
    import wb_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        in_drain;
    logic        has_cause;
    logic        has_ertn;
    logic        need_flush;

    assign in_drain   = (state == drain);
    assign has_cause  = stage.valid & (|stage.excp.bits);
    assign has_ertn   = stage.valid & stage.ertn;
    // wrong-path item in drain never flushes
    assign need_flush = (has_cause | has_ertn) & ~in_drain;

    // hold a flushing item until icache is idle
    assign stall      = need_flush & icache_busy;
    // drained item and held item both stay out of the register file
    assign squash     = in_drain | stall;

    // cause beats ertn when both are present
    assign flush_now  = has_cause & ~in_drain & ~icache_busy;
    assign ertn_now   = has_ertn & ~has_cause & ~in_drain & ~icache_busy;

    assign left_ready = stall ? 1'b0 : right_ready;

    always_comb begin
        case (state)
            idle, wait_icache: begin
                if (stall) begin
                    next_state = wait_icache;
                end else if (need_flush) begin
                    next_state = drain;
                end else begin
                    next_state = idle;
                end
            end
            // one cycle only, the wrong-path slot
            drain:   next_state = idle;
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/stable_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module stable_counter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    timer_hi,
    output logic [wb_pkg::xlen-1:0] timer_value
);
    import wb_pkg::*;

    logic [timer_w-1:0] count;

    // free running, first increment on the edge after reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // rdtimeh reads upper word, rdtimel lower
    assign timer_value = timer_hi ? count[timer_w-1:xlen] : count[xlen-1:0];

endmodule

`default_nettype wire

// ==== verilog/wb_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_commit (
    wb_stage_if.commit                     stage,
    input  logic                           squash,
    input  logic                           flush_now,
    input  logic                           ertn_now,
    input  logic                           right_ready,
    input  logic [wb_pkg::xlen-1:0]        timer_value,
    output logic                           timer_hi,
    output logic                           right_valid,
    output logic                           commit_valid,
    output logic                           rf_we,
    output logic [wb_pkg::reg_addr_w-1:0]  rf_waddr,
    output logic [wb_pkg::xlen-1:0]        rf_wdata,
    output logic                           bypass_we,
    output logic [wb_pkg::reg_addr_w-1:0]  bypass_waddr,
    output logic [wb_pkg::xlen-1:0]        bypass_wdata,
    output logic                           excp_flush,
    output logic                           ertn_flush,
    output logic [wb_pkg::xlen-1:0]        excp_era
);
    import wb_pkg::*;

    logic            live;
    logic            retire;
    logic [xlen-1:0] wdata;

    // present, not drained, not held for icache
    assign live   = stage.valid & ~squash;
    // a faulting instruction never retires
    assign retire = live & stage.inst_valid & ~flush_now;

    // timer reads pick a counter half by inst bit
    assign timer_hi = stage.inst[timer_hi_bit];
    assign wdata    = stage.timer_inst ? timer_value : stage.result;

    assign right_valid  = live;
    // counted once, on the consuming cycle
    assign commit_valid = retire & right_ready;

    // regfile written at presentation, repeat under back-pressure is harmless
    assign rf_we    = retire & stage.wreg_en;
    assign rf_waddr = stage.wreg_index;
    assign rf_wdata = wdata;

    // bypass is not gated by the flush
    assign bypass_we    = live & stage.wreg_en;
    assign bypass_waddr = stage.wreg_index;
    assign bypass_wdata = wdata;

    assign excp_flush = flush_now;
    assign ertn_flush = ertn_now;
    // era is the faulting pc
    assign excp_era   = stage.pc;

endmodule

`default_nettype wire

// ==== verilog/wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           icache_busy,
    input  logic                           left_valid,
    input  logic                           right_ready,
    input  logic [wb_pkg::xlen-1:0]        pc,
    input  logic [wb_pkg::xlen-1:0]        inst,
    input  logic [wb_pkg::xlen-1:0]        mem_result,
    input  logic [wb_pkg::xlen-1:0]        mem_addr,
    input  logic [wb_pkg::reg_addr_w-1:0]  wreg_index,
    input  logic                           wreg_en,
    input  logic                           inst_valid,
    input  logic                           timer_inst,
    input  wb_pkg::excp_vec_u              excp,
    input  logic                           ertn,
    output logic                           left_ready,
    output logic                           right_valid,
    output logic                           commit_valid,
    output logic                           rf_we,
    output logic [wb_pkg::reg_addr_w-1:0]  rf_waddr,
    output logic [wb_pkg::xlen-1:0]        rf_wdata,
    output logic                           bypass_we,
    output logic [wb_pkg::reg_addr_w-1:0]  bypass_waddr,
    output logic [wb_pkg::xlen-1:0]        bypass_wdata,
    output logic                           excp_flush,
    output logic                           ertn_flush,
    output logic                           stall,
    output logic [wb_pkg::xlen-1:0]        excp_era,
    output logic [wb_pkg::ecode_w-1:0]     ecode,
    output logic [wb_pkg::esubcode_w-1:0]  esubcode,
    output logic [wb_pkg::xlen-1:0]        badv,
    output logic                           badv_valid,
    output logic                           excp_tlb,
    output logic                           excp_tlbrefill
);

    logic                    squash;
    logic                    flush_now;
    logic                    ertn_now;
    logic                    timer_hi;
    logic [wb_pkg::xlen-1:0] timer_value;

    wb_stage_if u_stage ();

    // memory stage word straight into the interface
    assign u_stage.valid      = left_valid;
    assign u_stage.pc         = pc;
    assign u_stage.inst       = inst;
    assign u_stage.result     = mem_result;
    assign u_stage.mem_addr   = mem_addr;
    assign u_stage.wreg_index = wreg_index;
    assign u_stage.wreg_en    = wreg_en;
    assign u_stage.inst_valid = inst_valid;
    assign u_stage.timer_inst = timer_inst;
    assign u_stage.excp       = excp;
    assign u_stage.ertn       = ertn;

    flush_ctrl_fsm u_flush_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .stage       (u_stage),
        .icache_busy (icache_busy),
        .right_ready (right_ready),
        .left_ready  (left_ready),
        .stall       (stall),
        .squash      (squash),
        .flush_now   (flush_now),
        .ertn_now    (ertn_now)
    );

    excp_priority u_excp_priority (
        .stage          (u_stage),
        .ecode          (ecode),
        .esubcode       (esubcode),
        .badv           (badv),
        .badv_valid     (badv_valid),
        .excp_tlb       (excp_tlb),
        .excp_tlbrefill (excp_tlbrefill)
    );

    stable_counter u_stable_counter (
        .clk         (clk),
        .arst_n      (arst_n),
        .timer_hi    (timer_hi),
        .timer_value (timer_value)
    );

    wb_commit u_commit (
        .stage        (u_stage),
        .squash       (squash),
        .flush_now    (flush_now),
        .ertn_now     (ertn_now),
        .right_ready  (right_ready),
        .timer_value  (timer_value),
        .timer_hi     (timer_hi),
        .right_valid  (right_valid),
        .commit_valid (commit_valid),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .bypass_we    (bypass_we),
        .bypass_waddr (bypass_waddr),
        .bypass_wdata (bypass_wdata),
        .excp_flush   (excp_flush),
        .ertn_flush   (ertn_flush),
        .excp_era     (excp_era)
    );

endmodule

`default_nettype wire

// ==== tb/wb_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_assertions (
    input logic                clk,
    input logic                arst_n,
    input logic                stall,
    input logic                flush_now,
    input logic                ertn_now,
    input wb_pkg::ctrl_state_e state
);
    import wb_pkg::*;

    // read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // flush of either kind is a single-cycle pulse
    a_flush_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        (flush_now || ertn_now) |=> !(flush_now || ertn_now))
        else begin
            fail_count++;
            $error("flush pulse longer than one cycle");
        end

    // held item parks the FSM in the icache wait state
    a_stall_waits: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> (state == wait_icache))
        else begin
            fail_count++;
            $error("stall not followed by the icache wait state");
        end

    // wrong-path slot after every flush
    a_flush_drain: assert property (@(posedge clk) disable iff (!arst_n)
        (flush_now || ertn_now) |=> (state == drain))
        else begin
            fail_count++;
            $error("flush not followed by the drain state");
        end

endmodule

bind flush_ctrl_fsm wb_assertions u_wb_assertions (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (stall),
    .flush_now  (flush_now),
    .ertn_now   (ertn_now),
    .state      (state)
);

`default_nettype wire

// ==== tb/tb_wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_top;
    import wb_pkg::*;

    // expected cause encoding for one flushing instruction
    typedef struct packed {
        logic [ecode_w-1:0]    ecode;
        logic [esubcode_w-1:0] esubcode;
        logic [xlen-1:0]       badv;
        logic                  badv_valid;
        logic                  tlb;
        logic                  tlbrefill;
    } cause_t;

    localparam int max_cycles = 400;

    logic                  clk;
    logic                  arst_n;
    logic                  icache_busy;
    logic                  left_valid;
    logic                  right_ready;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       mem_result;
    logic [xlen-1:0]       mem_addr;
    logic [reg_addr_w-1:0] wreg_index;
    logic                  wreg_en;
    logic                  inst_valid;
    logic                  timer_inst;
    excp_vec_u             excp;
    logic                  ertn;
    logic                  left_ready;
    logic                  right_valid;
    logic                  commit_valid;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;
    logic                  bypass_we;
    logic [reg_addr_w-1:0] bypass_waddr;
    logic [xlen-1:0]       bypass_wdata;
    logic                  excp_flush;
    logic                  ertn_flush;
    logic                  stall;
    logic [xlen-1:0]       excp_era;
    logic [ecode_w-1:0]    ecode;
    logic [esubcode_w-1:0] esubcode;
    logic [xlen-1:0]       badv;
    logic                  badv_valid;
    logic                  excp_tlb;
    logic                  excp_tlbrefill;

    int          seed;
    int          errors;
    int          checks;
    int          cycles;
    int          busy_len;
    logic [31:0] rnd;
    string       test_name;
    // model state, drain slot and cycles since reset release
    logic        exp_drain;
    logic        next_drain;
    logic [63:0] tb_count;
    // expected values of the current cycle
    logic        has_cause;
    logic        has_ertn;
    logic        e_stall;
    logic        e_xflush;
    logic        e_rflush;
    logic        e_live;
    logic        e_rf_we;
    logic        e_bypass;
    logic        e_commit;
    logic [31:0] e_wdata;
    cause_t      e_cause;

    wb_top u_wb_top (.*);

    always #4 clk = ~clk;

    // lowest set cause wins, encoded from the cause table
    function automatic cause_t expect_cause(excp_vec_u v, logic [31:0] pc_v,
                                            logic [31:0] addr_v);
        cause_t r;
        int     first;
        r = '0;
        first = -1;
        for (int i = excp_w - 1; i >= 0; i--) begin
            if (v.bits[i]) first = i;
        end
        case (first)
            1, 10:   r.ecode = ecode_ade;
            2, 11:   r.ecode = ecode_tlbr;
            3:       r.ecode = ecode_pif;
            4, 13:   r.ecode = ecode_ppi;
            5:       r.ecode = ecode_sys;
            6:       r.ecode = ecode_brk;
            7:       r.ecode = ecode_ine;
            8:       r.ecode = ecode_ipe;
            9:       r.ecode = ecode_ale;
            12:      r.ecode = ecode_pme;
            14:      r.ecode = ecode_pis;
            15:      r.ecode = ecode_pil;
            default: r.ecode = ecode_int;
        endcase
        r.esubcode = (first == 10) ? esubcode_adem : esubcode_adef;
        // fetch faults report pc, data faults the access address
        if (first inside {[1:4]}) begin
            r.badv = pc_v;
            r.badv_valid = 1'b1;
        end else if (first inside {[9:15]}) begin
            r.badv = addr_v;
            r.badv_valid = 1'b1;
        end
        r.tlb = first inside {[2:4], [11:15]};
        r.tlbrefill = (first == 2) || (first == 11);
        return r;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        checks++;
        assert (exp_v === act_v) else begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // plain instruction with random fields and no cause
    task automatic random_item();
        left_valid = 1'b1;
        pc         = $random(seed);
        inst       = $random(seed);
        mem_result = $random(seed);
        mem_addr   = $random(seed);
        rnd        = $random(seed);
        wreg_index = rnd[4:0];
        wreg_en    = rnd[5];
        right_ready = rnd[6] | rnd[7];
        inst_valid = 1'b1;
        timer_inst = 1'b0;
        excp       = '0;
        ertn       = 1'b0;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_drain <= 1'b0;
            tb_count  <= '0;
        end else begin
            exp_drain <= next_drain;
            tb_count  <= tb_count + 64'd1;
        end
    end

    // compare at the falling edge, inputs settled since rise plus 1 ns
    always @(negedge clk) begin
        has_cause = left_valid && (excp.bits != '0);
        has_ertn  = left_valid && ertn;
        e_stall   = (has_cause || has_ertn) && !exp_drain && icache_busy;
        e_xflush  = has_cause && !exp_drain && !icache_busy;
        // cause takes precedence over ertn
        e_rflush  = has_ertn && !has_cause && !exp_drain && !icache_busy;
        e_live    = left_valid && !exp_drain && !e_stall;
        e_rf_we   = e_live && inst_valid && wreg_en && !e_xflush;
        // forwarding port sees the item even when it flushes
        e_bypass  = e_live && wreg_en;
        e_commit  = e_live && inst_valid && !e_xflush && right_ready;
        e_wdata   = timer_inst ? (inst[timer_hi_bit] ? tb_count[63:32] : tb_count[31:0])
                               : mem_result;
        check_val("stall", e_stall, stall);
        check_val("left_ready", !e_stall && right_ready, left_ready);
        check_val("right_valid", e_live, right_valid);
        check_val("rf_we", e_rf_we, rf_we);
        check_val("commit_valid", e_commit, commit_valid);
        check_val("excp_flush", e_xflush, excp_flush);
        check_val("ertn_flush", e_rflush, ertn_flush);
        check_val("bypass_we", e_bypass, bypass_we);
        if (e_rf_we) begin
            check_val("rf_waddr", wreg_index, rf_waddr);
            check_val("rf_wdata", e_wdata, rf_wdata);
        end
        if (e_bypass) begin
            check_val("bypass_waddr", wreg_index, bypass_waddr);
            check_val("bypass_wdata", e_wdata, bypass_wdata);
        end
        if (e_xflush) begin
            e_cause = expect_cause(excp, pc, mem_addr);
            check_val("ecode", e_cause.ecode, ecode);
            check_val("esubcode", e_cause.esubcode, esubcode);
            check_val("badv", e_cause.badv, badv);
            check_val("badv_valid", e_cause.badv_valid, badv_valid);
            check_val("excp_tlb", e_cause.tlb, excp_tlb);
            check_val("excp_tlbrefill", e_cause.tlbrefill, excp_tlbrefill);
            check_val("excp_era", pc, excp_era);
        end
        // every flush opens one drain slot
        next_drain = arst_n && (e_xflush || e_rflush);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        seed = 55868;
        errors = 0;
        checks = 0;
        cycles = 0;
        test_name = "reset";
        clk = 1'b0;
        arst_n = 1'b0;
        icache_busy = 1'b0;
        random_item();
        left_valid = 1'b0;
        right_ready = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_name = "normal retire";
        repeat (60) begin
            random_item();
            left_valid = rnd[8] | rnd[9];
            step();
        end

        // multi-bit causes, each followed by the wrong-path slot
        repeat (30) begin
            test_name = "exception priority";
            random_item();
            rnd = $random(seed);
            // random shift spreads the lowest set index over all causes
            excp.bits = rnd[15:0] << rnd[19:16];
            if (excp.bits == '0) excp.fields.ine = 1'b1;
            step();
            test_name = "drain squash";
            random_item();
            step();
            test_name = "after drain";
            random_item();
            step();
        end

        repeat (8) begin
            test_name = "icache wait";
            random_item();
            rnd = $random(seed);
            if (rnd[0]) excp.fields.ale = 1'b1;
            else ertn = 1'b1;
            icache_busy = 1'b1;
            busy_len = 1 + int'(rnd[2:1]);
            repeat (busy_len) step();
            icache_busy = 1'b0;
            step();
            test_name = "icache drain";
            random_item();
            step();
        end
        test_name = "normal under icache busy";
        icache_busy = 1'b1;
        repeat (10) begin
            random_item();
            step();
        end
        icache_busy = 1'b0;

        repeat (6) begin
            test_name = "ertn alone";
            random_item();
            ertn = 1'b1;
            step();
            random_item();
            step();
            test_name = "ertn with cause";
            random_item();
            ertn = 1'b1;
            excp.fields.sys = 1'b1;
            step();
            random_item();
            step();
        end

        // inst bit 10 picks the counter half
        test_name = "timer read";
        repeat (20) begin
            random_item();
            timer_inst = 1'b1;
            wreg_en = 1'b1;
            step();
        end

        left_valid = 1'b0;
        step();
        $display("checks: %0d, value errors: %0d, assertion errors: %0d", checks, errors,
                 u_wb_top.u_flush_ctrl.u_wb_assertions.fail_count);
        if (errors == 0 && u_wb_top.u_flush_ctrl.u_wb_assertions.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/wb_pkg.sv
verilog/wb_stage_if.sv
verilog/excp_priority.sv
verilog/flush_ctrl_fsm.sv
verilog/stable_counter.sv
verilog/wb_commit.sv
verilog/wb_top.sv
tb/wb_assertions.sv
tb/tb_wb_top.sv

// ==== Makefile ====
# Verilator flow for the writeback stage testbench
VERILATOR  ?= verilator
TOP        ?= tb_wb_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
